/* project.f */
source/mem_pkg.sv
source/issue_reg.sv
source/exe_mem_reg.sv
source/mem_ctrl_fsm.sv
source/mem_wb_reg.sv
source/mem_stage_top.sv
bench/mem_stage_checker.sv
bench/tb_mem_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_mem_stage -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/mem_stage_vectors.txt */
// columns: op rd alu_result rs2 exp_be exp_wdata (hex)
// op: 0 alu, 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 sb, 7 sh, 8 sw
0 01 12345678 00000000 0 00000000
5 02 00001000 00000000 f 00000000
8 00 00001004 deadbeef f deadbeef
6 00 00001001 000000a5 2 0000a500
7 00 00001002 0000beef c beef0000
1 03 00002003 00000000 8 00000000
2 04 00002002 00000000 4 00000000
3 05 00002002 00000000 c 00000000
4 06 00002000 00000000 3 00000000
0 07 cafef00d 00000000 0 00000000
6 00 00003003 11223344 8 44000000
7 00 00003000 aabbccdd 3 aabbccdd
5 08 80000010 00000000 f 00000000
0 09 00000003 00000000 0 00000000
8 00 7ffffffc 01020304 f 01020304
1 0a 00004000 00000000 1 00000000
6 00 00004002 ffffff5a 4 ff5a0000
0 1f ffffffff 00000000 0 00000000
4 0b 0000400e 00000000 c 00000000
7 00 00005006 12345678 c 56780000

/* bench/tb_mem_stage.sv */
`timescale 1ns/100ps

module tb_mem_stage;

    localparam int NUM_VEC    = 20;
    localparam int VEC_COLS   = 6;
    localparam int CLK_PERIOD = 4;
    localparam int ORDER_W    = mem_pkg::ORDER_W;
    localparam logic [31:0] SEED = 32'hee935c81;

    logic                       clk;
    logic                       rst;
    logic                       in_valid_i;
    mem_pkg::mem_op_e           in_op_i;
    logic [mem_pkg::REG_AW-1:0] in_rd_i;
    logic [mem_pkg::XLEN-1:0]   alu_result_i;
    logic [mem_pkg::XLEN-1:0]   rs2_data_i;
    logic                       in_ready_o;
    logic [mem_pkg::XLEN-1:0]   dmem_addr_o;
    logic [mem_pkg::BE_W-1:0]   dmem_be_o;
    logic [mem_pkg::XLEN-1:0]   dmem_wdata_o;
    logic                       dmem_read_o;
    logic                       dmem_write_o;
    logic                       dmem_resp_i;
    logic [mem_pkg::XLEN-1:0]   dmem_rdata_i;
    logic                       wb_valid_o;
    logic [mem_pkg::REG_AW-1:0] wb_rd_o;
    logic [mem_pkg::XLEN-1:0]   wb_data_o;
    logic [ORDER_W-1:0]         wb_order_o;
    logic [mem_pkg::BE_W-1:0]   exp_be;
    logic [mem_pkg::XLEN-1:0]   exp_wdata;
    logic [31:0]                vec_mem [0:NUM_VEC*VEC_COLS-1];
    logic [31:0]                drv_rng;
    logic [31:0]                mem_rng;
    int                         mem_wait;
    int                         bench_errors;
    int                         error_count;
    int                         wb_count;
    int                         ready_low_cycles;

    mem_stage_top #(.ORDER_W_P(ORDER_W)) u_dut (
        .clk(clk), .rst(rst),
        .in_valid_i(in_valid_i), .in_op_i(in_op_i), .in_rd_i(in_rd_i),
        .alu_result_i(alu_result_i), .rs2_data_i(rs2_data_i), .in_ready_o(in_ready_o),
        .dmem_addr_o(dmem_addr_o), .dmem_be_o(dmem_be_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_read_o(dmem_read_o), .dmem_write_o(dmem_write_o),
        .dmem_resp_i(dmem_resp_i), .dmem_rdata_i(dmem_rdata_i),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .wb_order_o(wb_order_o)
    );

    mem_stage_checker #(.ORDER_W_P(ORDER_W)) u_checker (
        .clk(clk), .rst(rst),
        .in_valid_i(in_valid_i), .in_ready_i(in_ready_o), .in_op_i(in_op_i),
        .in_rd_i(in_rd_i), .alu_result_i(alu_result_i),
        .exp_be_i(exp_be), .exp_wdata_i(exp_wdata),
        .dmem_addr_i(dmem_addr_o), .dmem_be_i(dmem_be_o), .dmem_wdata_i(dmem_wdata_o),
        .dmem_read_i(dmem_read_o), .dmem_write_i(dmem_write_o), .dmem_resp_i(dmem_resp_i),
        .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
        .wb_order_i(wb_order_o),
        .error_count_o(error_count), .wb_count_o(wb_count), .ready_low_o(ready_low_cycles)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // offer one vector and hold it until the DUT takes it
    task automatic send_item(input int idx);
        int   base;
        int   idle;
        logic taken;
        base    = idx * VEC_COLS;
        drv_rng = xorshift(drv_rng);
        idle    = int'(drv_rng % 3);
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        in_op_i      = mem_pkg::mem_op_e'(vec_mem[base][3:0]);
        in_rd_i      = vec_mem[base+1][mem_pkg::REG_AW-1:0];
        alu_result_i = vec_mem[base+2];
        rs2_data_i   = vec_mem[base+3];
        exp_be       = vec_mem[base+4][mem_pkg::BE_W-1:0];
        exp_wdata    = vec_mem[base+5];
        in_valid_i   = 1'b1;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready_o;
            @(posedge clk);
            #1;
        end
        in_valid_i = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cache model, random response latency
    initial begin
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = '0;
        mem_rng      = xorshift(SEED);
        mem_wait     = -1;
        forever begin
            @(posedge clk);
            #1;
            dmem_resp_i = 1'b0;
            if (dmem_read_o || dmem_write_o) begin
                if (mem_wait < 0) begin
                    mem_rng  = xorshift(mem_rng);
                    mem_wait = int'(mem_rng % 4);
                end
                if (mem_wait == 0) begin
                    dmem_resp_i  = 1'b1;
                    dmem_rdata_i = dmem_addr_o ^ 32'h5a5a5a5a;
                    mem_wait     = -1;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    initial begin
        #(NUM_VEC * 40 * CLK_PERIOD);
        $display("timeout: %0d of %0d writebacks after %0d cycles", wb_count, NUM_VEC,
                 NUM_VEC * 40);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        in_valid_i   = 1'b0;
        in_op_i      = mem_pkg::op_alu;
        in_rd_i      = '0;
        alu_result_i = '0;
        rs2_data_i   = '0;
        exp_be       = '0;
        exp_wdata    = '0;
        drv_rng      = SEED;
        bench_errors = 0;
        $readmemh("bench/mem_stage_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_VEC; i++) begin
            send_item(i);
        end
        while (wb_count < NUM_VEC) @(posedge clk);
        repeat (10) @(posedge clk);  // room for a stray extra writeback
        if (wb_count != NUM_VEC) begin
            $display("wrong number of writebacks: %0d for %0d items", wb_count, NUM_VEC);
            bench_errors++;
        end
        if (ready_low_cycles == 0) begin
            $display("in_ready_o never fell while cache requests were held");
            bench_errors++;
        end
        $display("summary: %0d checker errors, %0d bench errors, %0d of %0d writebacks",
                 error_count, bench_errors, wb_count, NUM_VEC);
        if (error_count == 0 && bench_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_mem_stage

/* bench/mem_stage_checker.sv */
`timescale 1ns/100ps

module mem_stage_checker #(
    parameter int ORDER_W_P = mem_pkg::ORDER_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid_i,
    input  logic                         in_ready_i,
    input  mem_pkg::mem_op_e             in_op_i,
    input  logic [mem_pkg::REG_AW-1:0]   in_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     alu_result_i,
    input  logic [mem_pkg::BE_W-1:0]     exp_be_i,
    input  logic [mem_pkg::XLEN-1:0]     exp_wdata_i,
    input  logic [mem_pkg::XLEN-1:0]     dmem_addr_i,
    input  logic [mem_pkg::BE_W-1:0]     dmem_be_i,
    input  logic [mem_pkg::XLEN-1:0]     dmem_wdata_i,
    input  logic                         dmem_read_i,
    input  logic                         dmem_write_i,
    input  logic                         dmem_resp_i,
    input  logic                         wb_valid_i,
    input  logic [mem_pkg::REG_AW-1:0]   wb_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     wb_data_i,
    input  logic [ORDER_W_P-1:0]         wb_order_i,
    output int                           error_count_o,
    output int                           wb_count_o,
    output int                           ready_low_o
);

    mem_pkg::mem_op_e           q_op[$];
    logic [mem_pkg::REG_AW-1:0] q_rd[$];
    logic [mem_pkg::XLEN-1:0]   q_res[$];
    logic [mem_pkg::BE_W-1:0]   q_be[$];
    logic [mem_pkg::XLEN-1:0]   q_wdata[$];
    logic [63:0]                next_order;
    logic                       req_seen;  // head item already made its request
    logic                       req_held;
    logic                       reset_checked;

    function automatic bit is_load(input mem_pkg::mem_op_e op);
        return op inside {mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_lh, mem_pkg::op_lhu,
                          mem_pkg::op_lw};
    endfunction

    function automatic bit is_store(input mem_pkg::mem_op_e op);
        return op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw};
    endfunction

    task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count_o++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        error_count_o++;
    endtask

    task automatic check_writeback();
        logic [31:0] exp_data;
        wb_count_o++;
        if (q_op.size() == 0) begin
            report_failure("writeback arrived with no item outstanding");
            return;
        end
        exp_data = is_load(q_op[0]) ? ({q_res[0][31:2], 2'b00} ^ 32'h5a5a5a5a) : q_res[0];
        compare_hex("wb_data_o", wb_data_i, exp_data);
        compare_hex("wb_rd_o", wb_rd_i, q_rd[0]);
        compare_hex("wb_order_o", wb_order_i, next_order);
        if (q_op[0] != mem_pkg::op_alu && !req_seen) begin
            report_failure("memory item written back without a cache request");
        end
        void'(q_op.pop_front());
        void'(q_rd.pop_front());
        void'(q_res.pop_front());
        void'(q_be.pop_front());
        void'(q_wdata.pop_front());
        next_order++;
        req_seen = 1'b0;
    endtask

    task automatic check_request();
        logic strobe;
        strobe = dmem_read_i || dmem_write_i;
        if (req_held && !strobe) report_failure("request dropped before the cache responded");
        if (strobe) begin
            if (q_op.size() == 0) begin
                report_failure("cache request with no item outstanding");
            end else if (!is_load(q_op[0]) && !is_store(q_op[0])) begin
                report_failure("cache request made for an ALU item");
            end else begin
                if (req_seen && !req_held) report_failure("second cache request for one item");
                compare_hex("dmem_addr_o", dmem_addr_i, {q_res[0][31:2], 2'b00});
                compare_hex("dmem_be_o", dmem_be_i, q_be[0]);
                compare_hex("dmem_read_o", dmem_read_i, is_load(q_op[0]));
                compare_hex("dmem_write_o", dmem_write_i, is_store(q_op[0]));
                if (is_store(q_op[0])) compare_hex("dmem_wdata_o", dmem_wdata_i, q_wdata[0]);
                req_seen = 1'b1;
            end
        end
        req_held = strobe && !dmem_resp_i;
    endtask

    // everything is settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            next_order    = '0;
            req_seen      = 1'b0;
            req_held      = 1'b0;
            reset_checked = 1'b0;
        end else begin
            if (!reset_checked) begin
                compare_hex("dmem_read_o", dmem_read_i, 1'b0);
                compare_hex("dmem_write_o", dmem_write_i, 1'b0);
                compare_hex("wb_valid_o", wb_valid_i, 1'b0);
                compare_hex("in_ready_o", in_ready_i, 1'b1);
                reset_checked = 1'b1;
            end
            if (!in_ready_i) ready_low_o++;
            if (wb_valid_i) check_writeback();  // retire before looking at the request
            check_request();
            if (in_valid_i && in_ready_i) begin
                q_op.push_back(in_op_i);
                q_rd.push_back(in_rd_i);
                q_res.push_back(alu_result_i);
                q_be.push_back(exp_be_i);
                q_wdata.push_back(exp_wdata_i);
            end
        end
    end

endmodule : mem_stage_checker

/* source/mem_stage_top.sv */
`timescale 1ns/100ps

module mem_stage_top #(
    parameter int ORDER_W_P = mem_pkg::ORDER_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid_i,
    input  mem_pkg::mem_op_e             in_op_i,
    input  logic [mem_pkg::REG_AW-1:0]   in_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     alu_result_i,
    input  logic [mem_pkg::XLEN-1:0]     rs2_data_i,
    output logic                         in_ready_o,
    output logic [mem_pkg::XLEN-1:0]     dmem_addr_o,
    output logic [mem_pkg::BE_W-1:0]     dmem_be_o,
    output logic [mem_pkg::XLEN-1:0]     dmem_wdata_o,
    output logic                         dmem_read_o,
    output logic                         dmem_write_o,
    input  logic                         dmem_resp_i,
    input  logic [mem_pkg::XLEN-1:0]     dmem_rdata_i,
    output logic                         wb_valid_o,
    output logic [mem_pkg::REG_AW-1:0]   wb_rd_o,
    output logic [mem_pkg::XLEN-1:0]     wb_data_o,
    output logic [ORDER_W_P-1:0]         wb_order_o
);

    logic                       exe_ld;
    logic                       wb_ld;
    logic                       issue_valid;
    mem_pkg::mem_op_e           issue_op;
    logic [mem_pkg::REG_AW-1:0] issue_rd;
    logic [mem_pkg::XLEN-1:0]   issue_result;
    logic [mem_pkg::XLEN-1:0]   issue_rs2;
    logic [ORDER_W_P-1:0]       issue_order;
    logic                       exe_valid;
    logic                       mem_rd_pend;
    logic                       mem_wr_pend;
    logic [mem_pkg::REG_AW-1:0] exe_rd;
    logic [mem_pkg::XLEN-1:0]   exe_result;
    logic [ORDER_W_P-1:0]       exe_order;

    issue_reg #(.ORDER_W_P(ORDER_W_P)) u_issue (
        .clk(clk), .rst(rst),
        .in_valid_i(in_valid_i), .in_op_i(in_op_i), .in_rd_i(in_rd_i),
        .alu_result_i(alu_result_i), .rs2_data_i(rs2_data_i), .exe_ld_i(exe_ld),
        .in_ready_o(in_ready_o), .issue_valid_o(issue_valid), .issue_op_o(issue_op),
        .issue_rd_o(issue_rd), .issue_result_o(issue_result), .issue_rs2_o(issue_rs2),
        .issue_order_o(issue_order)
    );

    exe_mem_reg #(.ORDER_W_P(ORDER_W_P)) u_exe_mem (
        .clk(clk), .rst(rst), .exe_ld_i(exe_ld),
        .issue_valid_i(issue_valid), .issue_op_i(issue_op), .issue_rd_i(issue_rd),
        .issue_result_i(issue_result), .issue_rs2_i(issue_rs2),
        .issue_order_i(issue_order), .wb_ld_i(wb_ld),
        .exe_valid_o(exe_valid), .mem_rd_pend_o(mem_rd_pend), .mem_wr_pend_o(mem_wr_pend),
        .dmem_addr_o(dmem_addr_o), .dmem_be_o(dmem_be_o), .dmem_wdata_o(dmem_wdata_o),
        .exe_rd_o(exe_rd), .exe_result_o(exe_result), .exe_order_o(exe_order)
    );

    mem_ctrl_fsm u_ctrl (
        .clk(clk), .rst(rst),
        .issue_valid_i(issue_valid), .exe_valid_i(exe_valid),
        .mem_rd_pend_i(mem_rd_pend), .mem_wr_pend_i(mem_wr_pend), .dmem_resp_i(dmem_resp_i),
        .exe_ld_o(exe_ld), .wb_ld_o(wb_ld),
        .dmem_read_o(dmem_read_o), .dmem_write_o(dmem_write_o)
    );

    mem_wb_reg #(.ORDER_W_P(ORDER_W_P)) u_mem_wb (
        .clk(clk), .rst(rst), .wb_ld_i(wb_ld),
        .mem_rd_pend_i(mem_rd_pend), .dmem_rdata_i(dmem_rdata_i),
        .exe_rd_i(exe_rd), .exe_result_i(exe_result), .exe_order_i(exe_order),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .wb_order_o(wb_order_o)
    );

endmodule : mem_stage_top

/* source/mem_wb_reg.sv */
`timescale 1ns/100ps

module mem_wb_reg #(
    parameter int ORDER_W_P = mem_pkg::ORDER_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_ld_i,
    input  logic                         mem_rd_pend_i,
    input  logic [mem_pkg::XLEN-1:0]     dmem_rdata_i,
    input  logic [mem_pkg::REG_AW-1:0]   exe_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     exe_result_i,
    input  logic [ORDER_W_P-1:0]         exe_order_i,
    output logic                         wb_valid_o,
    output logic [mem_pkg::REG_AW-1:0]   wb_rd_o,
    output logic [mem_pkg::XLEN-1:0]     wb_data_o,
    output logic [ORDER_W_P-1:0]         wb_order_o
);

    logic [mem_pkg::XLEN-1:0] wb_data_sel;

    // loads take the raw cache word, everything else the execute result
    assign wb_data_sel = mem_rd_pend_i ? dmem_rdata_i : exe_result_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= wb_ld_i;  // one pulse per item
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ld_i) begin
            wb_rd_o    <= exe_rd_i;
            wb_data_o  <= wb_data_sel;
            wb_order_o <= exe_order_i;
        end
    end

    // writeback numbers must come out strictly in order
    a_in_order : assert property (@(posedge clk) disable iff (rst)
        wb_ld_i && wb_valid_o |-> exe_order_i == wb_order_o + 1'b1);

endmodule : mem_wb_reg

/* source/mem_ctrl_fsm.sv */
`timescale 1ns/100ps

module mem_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid_i,
    input  logic exe_valid_i,
    input  logic mem_rd_pend_i,
    input  logic mem_wr_pend_i,
    input  logic dmem_resp_i,
    output logic exe_ld_o,
    output logic wb_ld_o,
    output logic dmem_read_o,
    output logic dmem_write_o
);

    mem_pkg::ctrl_state_e state_q;
    mem_pkg::ctrl_state_e state_d;
    logic                 mem_pend;

    assign mem_pend = mem_rd_pend_i || mem_wr_pend_i;

    always_comb begin
        state_d      = state_q;
        wb_ld_o      = 1'b0;
        dmem_read_o  = 1'b0;
        dmem_write_o = 1'b0;
        case (state_q)
            mem_pkg::st_idle: begin
                if (mem_pend) begin
                    state_d = mem_pkg::st_access;
                end else if (exe_valid_i) begin
                    wb_ld_o = 1'b1;  // alu item goes straight on
                end
            end
            mem_pkg::st_access: begin
                dmem_read_o  = mem_rd_pend_i;
                dmem_write_o = mem_wr_pend_i;
                if (dmem_resp_i) begin
                    wb_ld_o = 1'b1;
                    state_d = mem_pkg::st_idle;
                end
            end
            default: state_d = mem_pkg::st_idle;
        endcase
    end

    // only pull from issue when the execute slot is free or freeing
    assign exe_ld_o = issue_valid_i && (!exe_valid_i || wb_ld_o);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q <= mem_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    a_one_strobe : assert property (@(posedge clk) disable iff (rst)
        !(dmem_read_o && dmem_write_o));

    a_no_stray_resp : assert property (@(posedge clk) disable iff (rst)
        state_q == mem_pkg::st_idle |-> !dmem_resp_i);

endmodule : mem_ctrl_fsm

/* source/exe_mem_reg.sv */
`timescale 1ns/100ps

module exe_mem_reg #(
    parameter int ORDER_W_P = mem_pkg::ORDER_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         exe_ld_i,
    input  logic                         issue_valid_i,
    input  mem_pkg::mem_op_e             issue_op_i,
    input  logic [mem_pkg::REG_AW-1:0]   issue_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     issue_result_i,
    input  logic [mem_pkg::XLEN-1:0]     issue_rs2_i,
    input  logic [ORDER_W_P-1:0]         issue_order_i,
    input  logic                         wb_ld_i,
    output logic                         exe_valid_o,
    output logic                         mem_rd_pend_o,
    output logic                         mem_wr_pend_o,
    output logic [mem_pkg::XLEN-1:0]     dmem_addr_o,
    output logic [mem_pkg::BE_W-1:0]     dmem_be_o,
    output logic [mem_pkg::XLEN-1:0]     dmem_wdata_o,
    output logic [mem_pkg::REG_AW-1:0]   exe_rd_o,
    output logic [mem_pkg::XLEN-1:0]     exe_result_o,
    output logic [ORDER_W_P-1:0]         exe_order_o
);

    logic                       is_read;
    logic                       is_write;
    logic [1:0]                 size;  // 0 byte, 1 half, 2 word
    logic [1:0]                 offset;
    logic [mem_pkg::BE_W-1:0]   be_base;
    logic                       rd_q;
    logic                       wr_q;

    assign offset = issue_result_i[1:0];

    always_comb begin
        is_read  = 1'b0;
        is_write = 1'b0;
        size     = 2'd2;
        case (issue_op_i)
            mem_pkg::op_lb, mem_pkg::op_lbu: begin
                is_read = 1'b1;
                size    = 2'd0;
            end
            mem_pkg::op_lh, mem_pkg::op_lhu: begin
                is_read = 1'b1;
                size    = 2'd1;
            end
            mem_pkg::op_lw: is_read = 1'b1;
            mem_pkg::op_sb: begin
                is_write = 1'b1;
                size     = 2'd0;
            end
            mem_pkg::op_sh: begin
                is_write = 1'b1;
                size     = 2'd1;
            end
            mem_pkg::op_sw: is_write = 1'b1;
            default: ;  // alu item, no access
        endcase
    end

    always_comb begin
        case (size)
            2'd0:    be_base = {{(mem_pkg::BE_W-1){1'b0}}, 1'b1};
            2'd1:    be_base = {{(mem_pkg::BE_W-2){1'b0}}, 2'b11};
            default: be_base = '1;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            exe_valid_o <= 1'b0;
            rd_q        <= 1'b0;
            wr_q        <= 1'b0;
        end else if (exe_ld_i) begin
            exe_valid_o <= issue_valid_i;
            rd_q        <= is_read;
            wr_q        <= is_write;
        end else if (wb_ld_i) begin
            exe_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_ld_i) begin
            dmem_addr_o  <= {issue_result_i[mem_pkg::XLEN-1:2], 2'b00};
            dmem_be_o    <= (is_read || is_write) ? be_base << offset : '0;
            dmem_wdata_o <= issue_rs2_i << {offset, 3'b000};  // lane of the low byte
            exe_rd_o     <= issue_rd_i;
            exe_result_o <= issue_result_i;
            exe_order_o  <= issue_order_i;
        end
    end

    assign mem_rd_pend_o = exe_valid_o && rd_q;
    assign mem_wr_pend_o = exe_valid_o && wr_q;

    // upstream only sends naturally aligned accesses
    a_aligned : assert property (@(posedge clk) disable iff (rst)
        exe_ld_i && issue_valid_i && (is_read || is_write)
            |-> (size == 2'd0) || (size == 2'd1 && !offset[0]) || (offset == 2'd0));

endmodule : exe_mem_reg

/* source/issue_reg.sv */
`timescale 1ns/100ps

module issue_reg #(
    parameter int ORDER_W_P = mem_pkg::ORDER_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid_i,
    input  mem_pkg::mem_op_e             in_op_i,
    input  logic [mem_pkg::REG_AW-1:0]   in_rd_i,
    input  logic [mem_pkg::XLEN-1:0]     alu_result_i,
    input  logic [mem_pkg::XLEN-1:0]     rs2_data_i,
    input  logic                         exe_ld_i,
    output logic                         in_ready_o,
    output logic                         issue_valid_o,
    output mem_pkg::mem_op_e             issue_op_o,
    output logic [mem_pkg::REG_AW-1:0]   issue_rd_o,
    output logic [mem_pkg::XLEN-1:0]     issue_result_o,
    output logic [mem_pkg::XLEN-1:0]     issue_rs2_o,
    output logic [ORDER_W_P-1:0]         issue_order_o
);

    logic accept;
    logic [ORDER_W_P-1:0] order_cnt;

    assign in_ready_o    = !issue_valid_o || exe_ld_i;  // empty or draining
    assign accept        = in_valid_i && in_ready_o;
    assign issue_order_o = order_cnt;  // counter only moves with a new item

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            issue_valid_o <= 1'b0;
            order_cnt     <= '1;  // first item gets 0
        end else if (accept) begin
            issue_valid_o <= 1'b1;
            order_cnt     <= order_cnt + 1'b1;
        end else if (exe_ld_i) begin
            issue_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_op_o     <= in_op_i;
            issue_rd_o     <= in_rd_i;
            issue_result_o <= alu_result_i;
            issue_rs2_o    <= rs2_data_i;
        end
    end

    // source must hold a stalled item until it is taken
    a_hold_stable : assert property (@(posedge clk) disable iff (rst)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_op_i) && $stable(in_rd_i)
            && $stable(alu_result_i) && $stable(rs2_data_i));

endmodule : issue_reg

/* source/mem_pkg.sv */
package mem_pkg;

    localparam int XLEN    = 32;
    localparam int ORDER_W = 64;  // default commit order width
    localparam int REG_AW  = 5;
    localparam int BE_W    = XLEN / 8;

    typedef enum logic [3:0] {
        op_alu,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef enum logic {
        st_idle,
        st_access  // request out, waiting on cache
    } ctrl_state_e;

endpackage : mem_pkg
